// ==== source/wb_pkg.sv ====
// Shared write-back types and widths; register address width follows rf_depth, MPU codes are 2 bits
package wb_pkg;

  ////////////////////////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////////////////////////

  // Width of one integer data word
  localparam int unsigned xlen = 32;

  // Number of architectural integer registers including x0
  localparam int unsigned rf_depth = 32;

  // Register address width derived from the register count
  localparam int unsigned rf_addr_w = $clog2(rf_depth);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Register file address as carried down the pipeline
  typedef logic [rf_addr_w-1:0] rf_addr_t;

  // Result of the MPU check on a data access
  // The encoding keeps MPU_OK at zero so a cleared flop reads as no fault
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    // Load blocked by the MPU
    MPU_RE_FAULT = 2'b01,
    // Store blocked by the MPU
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

endpackage

// ==== source/ex_wb_pipe_reg.sv ====
// Holds one operation; a new one is taken only when empty or when write-back is ready this cycle
module ex_wb_pipe_reg import wb_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Execute side
  input  logic            ex_valid_i,
  input  logic            ex_rf_we_i,
  input  rf_addr_t        ex_rf_waddr_i,
  input  logic [xlen-1:0] ex_rf_wdata_i,
  input  logic            ex_lsu_en_i,
  input  logic            ex_xif_en_i,
  input  logic            ex_last_op_i,
  input  logic            ex_abort_op_i,
  output logic            ex_ready_o,

  // Write-back side
  input  logic            wb_ready_i,
  input  logic            kill_wb_i,
  output logic            pipe_valid_o,
  output logic            pipe_rf_we_o,
  output rf_addr_t        pipe_rf_waddr_o,
  output logic [xlen-1:0] pipe_rf_wdata_o,
  output logic            pipe_lsu_en_o,
  output logic            pipe_xif_en_o,
  output logic            pipe_last_op_o,
  output logic            pipe_abort_op_o
);

  logic capture;

  // Room for a new operation when the slot is empty or its content leaves this cycle
  assign ex_ready_o = !pipe_valid_o || wb_ready_i;

  // An operation moves over on an edge where both sides agree
  assign capture = ex_valid_i && ex_ready_o;

  // Valid bit and control flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid_o    <= 1'b0;
      pipe_rf_we_o    <= 1'b0;
      pipe_lsu_en_o   <= 1'b0;
      pipe_xif_en_o   <= 1'b0;
      pipe_last_op_o  <= 1'b0;
      pipe_abort_op_o <= 1'b0;
    end else begin
      if (capture) begin
        pipe_valid_o    <= 1'b1;
        pipe_rf_we_o    <= ex_rf_we_i;
        pipe_lsu_en_o   <= ex_lsu_en_i;
        pipe_xif_en_o   <= ex_xif_en_i;
        pipe_last_op_o  <= ex_last_op_i;
        pipe_abort_op_o <= ex_abort_op_i;
      end else if (kill_wb_i || wb_ready_i) begin
        // The held operation retired or was killed and nothing replaces it
        pipe_valid_o <= 1'b0;
      end
    end
  end

  // Address and data only matter while the valid bit is set
  always_ff @(posedge clk) begin
    if (capture) begin
      pipe_rf_waddr_o <= ex_rf_waddr_i;
      pipe_rf_wdata_o <= ex_rf_wdata_i;
    end
  end

endmodule

// ==== source/wb_stage.sv ====
// Combinational write-back except for sticky load flops; expects at most one load response per load
module wb_stage import wb_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Operation held in the EX/WB register
  input  logic            pipe_valid_i,
  input  logic            pipe_rf_we_i,
  input  rf_addr_t        pipe_rf_waddr_i,
  input  logic [xlen-1:0] pipe_rf_wdata_i,
  input  logic            pipe_lsu_en_i,
  input  logic            pipe_xif_en_i,
  input  logic            pipe_last_op_i,
  input  logic            pipe_abort_op_i,

  // Controller levels
  input  logic            halt_wb_i,
  input  logic            kill_wb_i,

  // Load response strobe
  input  logic            lsu_valid_i,
  input  logic [xlen-1:0] lsu_rdata_i,
  input  mpu_status_e     lsu_mpu_status_i,
  input  logic            lsu_wpt_match_i,
  output logic            lsu_valid_o,

  // Coprocessor result
  input  logic            xif_result_valid_i,
  input  logic [xlen-1:0] xif_result_data_i,
  input  logic            xif_result_exc_i,
  output logic            xif_result_ready_o,

  // Register file write port
  output logic            rf_we_o,
  output rf_addr_t        rf_waddr_o,
  output logic [xlen-1:0] rf_wdata_o,

  // Stage handshake and status
  output logic            wb_ready_o,
  output logic            wb_valid_o,
  output logic            data_stall_o,
  output logic            last_op_o,
  output logic            abort_op_o,
  output logic            wpt_match_o,
  output mpu_status_e     mpu_status_o
);

  logic            instr_valid;
  logic            lsu_exception;
  logic            xif_waiting;
  logic            xif_exception;

  // Sticky copies of the volatile load response
  logic            lsu_valid_q;
  logic            lsu_wpt_match_q;
  mpu_status_e     lsu_mpu_status_q;
  logic [xlen-1:0] lsu_rdata_q;

  // Response seen now or earlier, whichever applies
  logic            lsu_valid;
  logic            lsu_wpt_match;
  mpu_status_e     lsu_mpu_status;
  logic [xlen-1:0] lsu_rdata;

  // The operation may complete only when neither killed nor halted
  assign instr_valid = pipe_valid_i && !kill_wb_i && !halt_wb_i;

  // MPU faults only count for loads
  assign lsu_exception = pipe_lsu_en_i && (lsu_mpu_status != MPU_OK);

  ////////////////////////////////////////////////////////////
  // Coprocessor result
  ////////////////////////////////////////////////////////////

  // No result yet for the coprocessor operation in WB
  assign xif_waiting = pipe_valid_i && pipe_xif_en_i && !xif_result_valid_i;

  // Result arrived but flags a synchronous exception, so no write-back
  assign xif_exception = pipe_valid_i && pipe_xif_en_i && xif_result_valid_i && xif_result_exc_i;

  assign xif_result_ready_o = pipe_valid_i && pipe_xif_en_i;

  ////////////////////////////////////////////////////////////
  // Load response and sticky flops
  ////////////////////////////////////////////////////////////

  assign lsu_valid_o = pipe_valid_i && pipe_lsu_en_i;

  assign lsu_valid      = lsu_valid_q ? 1'b1             : lsu_valid_i;
  assign lsu_wpt_match  = lsu_valid_q ? lsu_wpt_match_q  : lsu_wpt_match_i;
  assign lsu_mpu_status = lsu_valid_q ? lsu_mpu_status_q : lsu_mpu_status_i;
  assign lsu_rdata      = lsu_valid_q ? lsu_rdata_q      : lsu_rdata_i;

  // A response that could not retire in its own cycle is kept until retire or kill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_valid_q      <= 1'b0;
      lsu_wpt_match_q  <= 1'b0;
      lsu_mpu_status_q <= MPU_OK;
    end else if (wb_valid_o || kill_wb_i) begin
      lsu_valid_q      <= 1'b0;
      lsu_wpt_match_q  <= 1'b0;
      lsu_mpu_status_q <= MPU_OK;
    end else if (lsu_valid_i) begin
      lsu_valid_q      <= 1'b1;
      lsu_wpt_match_q  <= lsu_wpt_match_i;
      lsu_mpu_status_q <= lsu_mpu_status_i;
    end
  end

  // Load data for a halted load, read only while lsu_valid_q is set
  always_ff @(posedge clk) begin
    if (lsu_valid_i) begin
      lsu_rdata_q <= lsu_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////////////////////////

  // Loads write only once their data is present, faulted or matched loads never
  assign rf_we_o = pipe_rf_we_i && instr_valid && !lsu_exception && !lsu_wpt_match
                   && !xif_waiting && !xif_exception && !(pipe_lsu_en_i && !lsu_valid);

  assign rf_waddr_o = pipe_rf_waddr_i;

  assign rf_wdata_o = pipe_lsu_en_i ? lsu_rdata         :
                      pipe_xif_en_i ? xif_result_data_i :
                                      pipe_rf_wdata_i;

  ////////////////////////////////////////////////////////////
  // Stage status
  ////////////////////////////////////////////////////////////

  // Waiting on the load response
  assign data_stall_o = pipe_lsu_en_i && !lsu_valid && instr_valid;

  // Kill always frees the stage, otherwise every wait source holds it
  assign wb_ready_o = kill_wb_i || (!data_stall_o && !xif_waiting && !halt_wb_i);

  // One pulse per retired operation, exceptions included
  assign wb_valid_o = instr_valid &&
                      ((!pipe_lsu_en_i && !xif_waiting) || (pipe_lsu_en_i && lsu_valid));

  assign last_op_o = pipe_valid_i && pipe_last_op_i;

  // MPU fault or watchpoint match on a load ends the sequence as well
  assign abort_op_o = pipe_valid_i &&
                      (pipe_abort_op_i || lsu_exception || (pipe_lsu_en_i && lsu_wpt_match));

  assign wpt_match_o  = lsu_wpt_match;
  assign mpu_status_o = lsu_mpu_status;

endmodule

// ==== source/reg_file.sv ====
// Integer register file with one write and one combinational read port; x0 always reads zero
module reg_file import wb_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Write port, sampled at the rising edge
  input  logic            we_i,
  input  rf_addr_t        waddr_i,
  input  logic [xlen-1:0] wdata_i,

  // Read port
  input  rf_addr_t        raddr_i,
  output logic [xlen-1:0] rdata_o
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // x0 has no storage, only x1 and up are real flops
  logic [xlen-1:0] mem [1:rf_depth-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < rf_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // Writes to x0 fall through here without effect
      mem[waddr_i] <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read
  ////////////////////////////////////////////////////////////

  // New data becomes visible the cycle after the write edge
  assign rdata_o = (raddr_i == '0) ? '0 : mem[raddr_i];

endmodule

// ==== source/wb_subsystem.sv ====
// Write-back end of the pipeline; results are observed only through the single register read port
module wb_subsystem import wb_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Execute side
  input  logic            ex_valid_i,
  input  logic            ex_rf_we_i,
  input  rf_addr_t        ex_rf_waddr_i,
  input  logic [xlen-1:0] ex_rf_wdata_i,
  input  logic            ex_lsu_en_i,
  input  logic            ex_xif_en_i,
  input  logic            ex_last_op_i,
  input  logic            ex_abort_op_i,
  output logic            ex_ready_o,

  // Load side
  output logic            lsu_valid_o,
  input  logic            lsu_valid_i,
  input  logic [xlen-1:0] lsu_rdata_i,
  input  mpu_status_e     lsu_mpu_status_i,
  input  logic            lsu_wpt_match_i,

  // Coprocessor side
  input  logic            xif_result_valid_i,
  input  logic [xlen-1:0] xif_result_data_i,
  input  logic            xif_result_exc_i,
  output logic            xif_result_ready_o,

  // Controller
  input  logic            halt_wb_i,
  input  logic            kill_wb_i,

  // Observation
  input  rf_addr_t        rd_addr_i,
  output logic [xlen-1:0] rd_data_o,
  output logic            wb_valid_o,
  output logic            data_stall_o,
  output logic            last_op_o,
  output logic            abort_op_o,
  output logic            wpt_match_o,
  output mpu_status_e     mpu_status_o
);

  // EX/WB register contents
  logic            pipe_valid;
  logic            pipe_rf_we;
  rf_addr_t        pipe_rf_waddr;
  logic [xlen-1:0] pipe_rf_wdata;
  logic            pipe_lsu_en;
  logic            pipe_xif_en;
  logic            pipe_last_op;
  logic            pipe_abort_op;

  // Back-pressure and register write port
  logic            wb_ready;
  logic            rf_we;
  rf_addr_t        rf_waddr;
  logic [xlen-1:0] rf_wdata;

  ex_wb_pipe_reg u_ex_wb_pipe_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_i),
    .ex_rf_we_i      (ex_rf_we_i),
    .ex_rf_waddr_i   (ex_rf_waddr_i),
    .ex_rf_wdata_i   (ex_rf_wdata_i),
    .ex_lsu_en_i     (ex_lsu_en_i),
    .ex_xif_en_i     (ex_xif_en_i),
    .ex_last_op_i    (ex_last_op_i),
    .ex_abort_op_i   (ex_abort_op_i),
    .ex_ready_o      (ex_ready_o),
    .wb_ready_i      (wb_ready),
    .kill_wb_i       (kill_wb_i),
    .pipe_valid_o    (pipe_valid),
    .pipe_rf_we_o    (pipe_rf_we),
    .pipe_rf_waddr_o (pipe_rf_waddr),
    .pipe_rf_wdata_o (pipe_rf_wdata),
    .pipe_lsu_en_o   (pipe_lsu_en),
    .pipe_xif_en_o   (pipe_xif_en),
    .pipe_last_op_o  (pipe_last_op),
    .pipe_abort_op_o (pipe_abort_op)
  );

  wb_stage u_wb_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .pipe_valid_i       (pipe_valid),
    .pipe_rf_we_i       (pipe_rf_we),
    .pipe_rf_waddr_i    (pipe_rf_waddr),
    .pipe_rf_wdata_i    (pipe_rf_wdata),
    .pipe_lsu_en_i      (pipe_lsu_en),
    .pipe_xif_en_i      (pipe_xif_en),
    .pipe_last_op_i     (pipe_last_op),
    .pipe_abort_op_i    (pipe_abort_op),
    .halt_wb_i          (halt_wb_i),
    .kill_wb_i          (kill_wb_i),
    .lsu_valid_i        (lsu_valid_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .lsu_mpu_status_i   (lsu_mpu_status_i),
    .lsu_wpt_match_i    (lsu_wpt_match_i),
    .lsu_valid_o        (lsu_valid_o),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_data_i  (xif_result_data_i),
    .xif_result_exc_i   (xif_result_exc_i),
    .xif_result_ready_o (xif_result_ready_o),
    .rf_we_o            (rf_we),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .wb_ready_o         (wb_ready),
    .wb_valid_o         (wb_valid_o),
    .data_stall_o       (data_stall_o),
    .last_op_o          (last_op_o),
    .abort_op_o         (abort_op_o),
    .wpt_match_o        (wpt_match_o),
    .mpu_status_o       (mpu_status_o)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rd_addr_i),
    .rdata_o (rd_data_o)
  );

endmodule

// ==== verification/wb_checker.sv ====
// Models register file and WB timing from observed ports; load responses must come while the load is in WB
module wb_checker import wb_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            ex_valid_i,
  input  logic            ex_rf_we_i,
  input  rf_addr_t        ex_rf_waddr_i,
  input  logic            ex_lsu_en_i,
  input  logic            ex_xif_en_i,
  input  logic            ex_last_op_i,
  input  logic            ex_abort_op_i,
  input  logic [xlen-1:0] ex_rf_wdata_i,
  input  logic            ex_ready_i,
  input  logic            lsu_valid_i,
  input  logic [xlen-1:0] lsu_rdata_i,
  input  mpu_status_e     lsu_mpu_status_i,
  input  logic            lsu_wpt_match_i,
  input  logic            lsu_req_i,
  input  logic            xif_result_valid_i,
  input  logic [xlen-1:0] xif_result_data_i,
  input  logic            xif_result_exc_i,
  input  logic            xif_result_ready_i,
  input  logic            halt_wb_i,
  input  logic            kill_wb_i,
  input  rf_addr_t        rd_addr_i,
  input  logic [xlen-1:0] rd_data_i,
  input  logic            wb_valid_i,
  input  logic            data_stall_i,
  input  logic            last_op_i,
  input  logic            abort_op_i,
  input  logic            wpt_match_i,
  input  mpu_status_e     mpu_status_i,
  input  logic            check_req_i,
  input  int              test_idx_i,
  input  logic [xlen-1:0] expect_data_i,
  input  logic            report_i,
  output int              errors_o
);

  logic [xlen-1:0] model [0:rf_depth-1];

  // Operation the model believes is in WB
  logic            busy;
  logic            op_we;
  logic            op_load;
  logic            op_xif;
  logic            op_last;
  logic            op_abort;
  rf_addr_t        op_dest;
  logic [xlen-1:0] op_data;

  // Model copy of a load response that arrived while halted
  logic            resp_seen;
  mpu_status_e     resp_status;
  logic            resp_match;
  logic [xlen-1:0] resp_data;

  // Values for the current cycle
  logic            resp_now;
  mpu_status_e     status_now;
  logic            match_now;
  logic [xlen-1:0] wdata_now;
  logic            exp_retire;
  logic            exp_stall;
  logic            xif_wait;
  logic            exp_ready;
  logic            write_ok;

  int              errors;
  int              test_base;
  int              tests;
  int              ops;
  int              killed;
  int              pulses;

  assign errors_o = errors;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Per-cycle model sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < rf_depth; i++) begin
        model[i] = '0;
      end
      busy      = 1'b0;
      resp_seen = 1'b0;
      errors    = 0;
      test_base = 0;
      tests     = 0;
      ops       = 0;
      killed    = 0;
      pulses    = 0;
    end else begin
      if (check_req_i) begin
        compare_value("rd_data_o", rd_data_i, model[rd_addr_i]);
        compare_value("rd_data_o", rd_data_i, expect_data_i);
        $display("test %0d: %s", test_idx_i, (errors == test_base) ? "pass" : "fail");
        test_base = errors;
        tests++;
      end
      // A sticky response wins over the live strobe
      resp_now   = resp_seen || lsu_valid_i;
      status_now = resp_seen ? resp_status : lsu_mpu_status_i;
      match_now  = resp_seen ? resp_match : lsu_wpt_match_i;
      wdata_now  = op_load ? (resp_seen ? resp_data : lsu_rdata_i) :
                   op_xif  ? xif_result_data_i : op_data;
      exp_retire = busy && !kill_wb_i && !halt_wb_i &&
                   (op_load ? resp_now : (op_xif ? xif_result_valid_i : 1'b1));
      exp_stall  = busy && op_load && !resp_now && !kill_wb_i && !halt_wb_i;
      xif_wait   = busy && op_xif && !xif_result_valid_i;
      exp_ready  = !busy || kill_wb_i || (!exp_stall && !xif_wait && !halt_wb_i);
      write_ok   = op_we && !(op_load && (status_now != MPU_OK || match_now)) &&
                   !(op_xif && xif_result_exc_i);
      compare_value("wb_valid_o", 32'(wb_valid_i), 32'(exp_retire));
      compare_value("data_stall_o", 32'(data_stall_i), 32'(exp_stall));
      compare_value("ex_ready_o", 32'(ex_ready_i), 32'(exp_ready));
      compare_value("lsu_valid_o", 32'(lsu_req_i), 32'(busy && op_load));
      compare_value("xif_result_ready_o", 32'(xif_result_ready_i), 32'(busy && op_xif));
      compare_value("last_op_o", 32'(last_op_i), 32'(busy && op_last));
      compare_value("abort_op_o", 32'(abort_op_i),
                    32'(busy && (op_abort ||
                                 (op_load && resp_now && (status_now != MPU_OK || match_now)))));
      compare_value("mpu_status_o", 32'(mpu_status_i),
                    32'((busy && op_load && resp_now) ? status_now : MPU_OK));
      compare_value("wpt_match_o", 32'(wpt_match_i),
                    32'(busy && op_load && resp_now && match_now));
      if (wb_valid_i) begin
        pulses++;
      end
      // State for the coming edge
      if (busy) begin
        if (kill_wb_i) begin
          killed++;
          busy = 1'b0;
        end else if (exp_retire) begin
          if (write_ok && op_dest != '0) begin
            model[op_dest] = wdata_now;
          end
          busy = 1'b0;
        end else if (op_load && lsu_valid_i) begin
          resp_seen   = 1'b1;
          resp_status = lsu_mpu_status_i;
          resp_match  = lsu_wpt_match_i;
          resp_data   = lsu_rdata_i;
        end
      end
      if (ex_valid_i && ex_ready_i) begin
        busy      = 1'b1;
        op_we     = ex_rf_we_i;
        op_load   = ex_lsu_en_i;
        op_xif    = ex_xif_en_i;
        op_last   = ex_last_op_i;
        op_abort  = ex_abort_op_i;
        op_dest   = ex_rf_waddr_i;
        op_data   = ex_rf_wdata_i;
        resp_seen = 1'b0;
        ops++;
      end
      if (report_i) begin
        if (pulses != ops - killed) begin
          $display("wb_valid_o pulsed %0d times for %0d operations that were not killed",
                   pulses, ops - killed);
          errors++;
        end
        $display("Summary: %0d tests, %0d operations, %0d killed, %0d retire pulses, %0d errors",
                 tests, ops, killed, pulses, errors);
      end
    end
  end

endmodule

// ==== verification/wb_tb.sv ====
// Runs verification/wb_vectors.txt one operation at a time; at most 32 lines, ended by a kind f line
module wb_tb import wb_pkg::*;;

  ////////////////////////////////////////////////////////////
  // Clock, reset and DUT ports
  ////////////////////////////////////////////////////////////

  logic            clk;
  logic            rst_n;

  logic            ex_valid_i;
  logic            ex_rf_we_i;
  rf_addr_t        ex_rf_waddr_i;
  logic [xlen-1:0] ex_rf_wdata_i;
  logic            ex_lsu_en_i;
  logic            ex_xif_en_i;
  logic            ex_last_op_i;
  logic            ex_abort_op_i;
  logic            ex_ready_o;
  logic            lsu_valid_o;
  logic            lsu_valid_i;
  logic [xlen-1:0] lsu_rdata_i;
  mpu_status_e     lsu_mpu_status_i;
  logic            lsu_wpt_match_i;
  logic            xif_result_valid_i;
  logic [xlen-1:0] xif_result_data_i;
  logic            xif_result_exc_i;
  logic            xif_result_ready_o;
  logic            halt_wb_i;
  logic            kill_wb_i;
  rf_addr_t        rd_addr_i;
  logic [xlen-1:0] rd_data_o;
  logic            wb_valid_o;
  logic            data_stall_o;
  logic            last_op_o;
  logic            abort_op_o;
  logic            wpt_match_o;
  mpu_status_e     mpu_status_o;

  // Requests to the checker
  logic            check_req;
  int              test_idx;
  logic [xlen-1:0] expect_data;
  logic            report;
  int              check_errors;

  // One 100-bit word per operation as laid out by the column line in the vectors file
  logic [99:0]     vectors [0:31];
  int              vec_count;

  wb_subsystem dut (.*);

  wb_checker chk (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_i),
    .ex_rf_we_i         (ex_rf_we_i),
    .ex_rf_waddr_i      (ex_rf_waddr_i),
    .ex_lsu_en_i        (ex_lsu_en_i),
    .ex_xif_en_i        (ex_xif_en_i),
    .ex_last_op_i       (ex_last_op_i),
    .ex_abort_op_i      (ex_abort_op_i),
    .ex_rf_wdata_i      (ex_rf_wdata_i),
    .ex_ready_i         (ex_ready_o),
    .lsu_valid_i        (lsu_valid_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .lsu_mpu_status_i   (lsu_mpu_status_i),
    .lsu_wpt_match_i    (lsu_wpt_match_i),
    .lsu_req_i          (lsu_valid_o),
    .xif_result_valid_i (xif_result_valid_i),
    .xif_result_data_i  (xif_result_data_i),
    .xif_result_exc_i   (xif_result_exc_i),
    .xif_result_ready_i (xif_result_ready_o),
    .halt_wb_i          (halt_wb_i),
    .kill_wb_i          (kill_wb_i),
    .rd_addr_i          (rd_addr_i),
    .rd_data_i          (rd_data_o),
    .wb_valid_i         (wb_valid_o),
    .data_stall_i       (data_stall_o),
    .last_op_i          (last_op_o),
    .abort_op_i         (abort_op_o),
    .wpt_match_i        (wpt_match_o),
    .mpu_status_i       (mpu_status_o),
    .check_req_i        (check_req),
    .test_idx_i         (test_idx),
    .expect_data_i      (expect_data),
    .report_i           (report),
    .errors_o           (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Driver for one vector
  ////////////////////////////////////////////////////////////

  // Entered and left 1 time unit after a rising edge
  task automatic run_operation(input logic [99:0] vec, input int idx, input bit last);
    logic [3:0]      kind;
    logic [xlen-1:0] data;
    int              delay;
    int              halt_len;
    logic            kill;
    int              k;
    bit              done;
    kind     = vec[99:96];
    data     = vec[87:56];
    delay    = int'(vec[55:52]);
    halt_len = int'(vec[39:36]);
    kill     = vec[32];
    ex_valid_i    = 1'b1;
    ex_rf_we_i    = 1'b1;
    ex_rf_waddr_i = vec[92:88];
    // ALU data differs from the load and coprocessor data so a wrong mux shows up
    ex_rf_wdata_i = (kind == 4'h0) ? data : ~data;
    ex_lsu_en_i   = (kind == 4'h1);
    ex_xif_en_i   = (kind == 4'h2);
    ex_last_op_i  = last;
    // Odd operations arrive with an abort from execute
    ex_abort_op_i = idx[0];
    @(negedge clk);
    while (!ex_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    ex_valid_i = 1'b0;
    // Cycle k counts from the first cycle the operation sits in WB
    k = 0;
    done = 1'b0;
    while (!done) begin
      lsu_valid_i        = (kind == 4'h1) && !kill && (k == delay);
      lsu_rdata_i        = lsu_valid_i ? data : '0;
      lsu_mpu_status_i   = lsu_valid_i ? mpu_status_e'(vec[49:48]) : MPU_OK;
      lsu_wpt_match_i    = lsu_valid_i && vec[44];
      xif_result_valid_i = (kind == 4'h2) && !kill && (k >= delay);
      xif_result_data_i  = xif_result_valid_i ? data : '0;
      xif_result_exc_i   = xif_result_valid_i && vec[40];
      // Halt starts with the response, so a halted load must use its sticky copy
      halt_wb_i          = (k >= delay) && (k < delay + halt_len);
      kill_wb_i          = kill && (k == 0);
      @(negedge clk);
      done = wb_valid_o || kill_wb_i;
      @(posedge clk);
      #1;
      k++;
    end
    lsu_valid_i        = 1'b0;
    lsu_rdata_i        = '0;
    lsu_mpu_status_i   = MPU_OK;
    lsu_wpt_match_i    = 1'b0;
    xif_result_valid_i = 1'b0;
    xif_result_data_i  = '0;
    xif_result_exc_i   = 1'b0;
    halt_wb_i          = 1'b0;
    kill_wb_i          = 1'b0;
    // Read back the destination once the write edge has passed
    rd_addr_i   = vec[92:88];
    expect_data = vec[31:0];
    test_idx    = idx;
    check_req   = 1'b1;
    @(posedge clk);
    #1;
    check_req = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n              = 1'b0;
    ex_valid_i         = 1'b0;
    ex_rf_we_i         = 1'b0;
    ex_rf_waddr_i      = '0;
    ex_rf_wdata_i      = '0;
    ex_lsu_en_i        = 1'b0;
    ex_xif_en_i        = 1'b0;
    ex_last_op_i       = 1'b0;
    ex_abort_op_i      = 1'b0;
    lsu_valid_i        = 1'b0;
    lsu_rdata_i        = '0;
    lsu_mpu_status_i   = MPU_OK;
    lsu_wpt_match_i    = 1'b0;
    xif_result_valid_i = 1'b0;
    xif_result_data_i  = '0;
    xif_result_exc_i   = 1'b0;
    halt_wb_i          = 1'b0;
    kill_wb_i          = 1'b0;
    rd_addr_i          = '0;
    check_req          = 1'b0;
    test_idx           = 0;
    expect_data        = '0;
    report             = 1'b0;
    $readmemh("verification/wb_vectors.txt", vectors);
    vec_count = 0;
    while (vec_count < 32 && vectors[vec_count][99:96] != 4'hf) begin
      vec_count++;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < vec_count; i++) begin
      run_operation(vectors[i], i, i == vec_count - 1);
    end
    report = 1'b1;
    @(posedge clk);
    #1;
    report = 1'b0;
    if (vec_count == 0) begin
      $display("No operations were read from the vectors file");
    end
    if (check_errors == 0 && vec_count > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog sized from the number of vectors
  initial begin
    #1;
    repeat (vec_count * 40 + 200) @(posedge clk);
    $display("Watchdog expired after %0d cycles before all operations finished",
             vec_count * 40 + 200);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== verification/wb_vectors.txt ====
// kind_dest_data_delay_mpu_match_exc_halt_kill_expect, one operation per line in hex
// kind 0 ALU, 1 load, 2 coprocessor, f ends the list; delay and halt count cycles in WB
0_05_1234abcd_0_0_0_0_0_0_1234abcd
0_00_ffffffff_0_0_0_0_0_0_00000000
1_06_cafef00d_3_0_0_0_0_0_cafef00d
1_07_0badbeef_0_0_0_0_0_0_0badbeef
1_06_11111111_2_1_0_0_0_0_cafef00d
1_07_22222222_1_0_1_0_3_0_0badbeef
1_06_33333333_0_1_0_0_2_0_cafef00d
1_08_5a5aa5a5_2_0_0_0_2_0_5a5aa5a5
2_09_87654321_4_0_0_0_0_0_87654321
2_09_deadbeef_1_0_0_1_0_0_87654321
0_05_99999999_0_0_0_0_0_1_1234abcd
0_0a_13572468_0_0_0_0_3_0_13572468
f_00_00000000_0_0_0_0_0_0_00000000

// ==== project.f ====
source/wb_pkg.sv
source/ex_wb_pipe_reg.sv
source/wb_stage.sv
source/reg_file.sv
source/wb_subsystem.sv
verification/wb_checker.sv
verification/wb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module wb_tb -o wb_sim
./obj_dir/wb_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
